// ==== include/decode_params.svh ====
`ifndef DECODE_PARAMS_SVH
`define DECODE_PARAMS_SVH

// Datapath widths
`define ADDR_WIDTH      32
`define DATA_WIDTH      32
`define GPR_NUM         32
`define ALU_OP_WIDTH    8
`define ALU_SEL_WIDTH   3
`define EXCP_WIDTH      2

// Instruction field widths
`define OPC_3R_WIDTH    17
`define OPC_2RI12_WIDTH 10
`define IMM12_WIDTH     12

// 3R opcodes, instr[31:15]
`define EXE_ADD_W    17'h00020
`define EXE_SUB_W    17'h00022
`define EXE_SLT      17'h00024
`define EXE_SLTU     17'h00025
`define EXE_NOR      17'h00028
`define EXE_AND      17'h00029
`define EXE_OR       17'h0002a
`define EXE_XOR      17'h0002b
`define EXE_SLL_W    17'h0002e
`define EXE_SRL_W    17'h0002f
`define EXE_SRA_W    17'h00030
`define EXE_MUL_W    17'h00038
`define EXE_MULH_W   17'h00039
`define EXE_MULH_WU  17'h0003a
`define EXE_DIV_W    17'h00040
`define EXE_MOD_W    17'h00041
`define EXE_DIV_WU   17'h00042
`define EXE_MOD_WU   17'h00043
`define EXE_BREAK    17'h00054
`define EXE_SYSCALL  17'h00056
`define EXE_IDLE     17'h00c91
`define EXE_INVTLB   17'h00c93
`define EXE_DBAR     17'h070e4
`define EXE_IBAR     17'h070e5

// 2RI12 opcodes, instr[31:22]
`define EXE_SLTI     10'h008
`define EXE_SLTUI    10'h009
`define EXE_ADDI_W   10'h00a
`define EXE_ANDI     10'h00d
`define EXE_ORI      10'h00e
`define EXE_XORI     10'h00f

// ALU operations
`define EXE_NOP_OP    8'd0
`define EXE_ADD_OP    8'd1
`define EXE_SUB_OP    8'd2
`define EXE_SLT_OP    8'd3
`define EXE_SLTU_OP   8'd4
`define EXE_NOR_OP    8'd5
`define EXE_AND_OP    8'd6
`define EXE_OR_OP     8'd7
`define EXE_XOR_OP    8'd8
`define EXE_SLL_OP    8'd9
`define EXE_SRL_OP    8'd10
`define EXE_SRA_OP    8'd11
`define EXE_MUL_OP    8'd12
`define EXE_MULH_OP   8'd13
`define EXE_MULHU_OP  8'd14
`define EXE_DIV_OP    8'd15
`define EXE_DIVU_OP   8'd16
`define EXE_MOD_OP    8'd17
`define EXE_MODU_OP   8'd18
`define EXE_INVTLB_OP 8'd19

// Result selectors
`define EXE_RES_NOP   3'd0
`define EXE_RES_LOGIC 3'd1
`define EXE_RES_SHIFT 3'd2
`define EXE_RES_ARITH 3'd3

// Exception codes
`define EXCP_NONE 2'd0
`define EXCP_BRK  2'd1
`define EXCP_SYS  2'd2
`define EXCP_INE  2'd3

`endif

// ==== design/decode_pkg.sv ====
`include "decode_params.svh"

package decode_pkg;

    // Plain vectors with a meaning
    typedef logic [`ADDR_WIDTH-1:0]       addr_t;
    typedef logic [`DATA_WIDTH-1:0]       word_t;
    typedef logic [$clog2(`GPR_NUM)-1:0]  reg_addr_t;
    typedef logic [`ALU_OP_WIDTH-1:0]     alu_op_t;
    typedef logic [`ALU_SEL_WIDTH-1:0]    alu_sel_t;
    typedef logic [`EXCP_WIDTH-1:0]       excp_code_t;

    // Entry handed over by the instruction buffer
    typedef struct packed {
        logic  valid;
        addr_t pc;
        word_t instr;
    } instr_buffer_info_t;

    // Output of one format decoder
    typedef struct packed {
        logic       decode_valid;
        // {rj, rk}
        logic [1:0] reg_read_valid;
        reg_addr_t  [1:0] reg_read_addr;
        // rd
        logic       reg_write_valid;
        reg_addr_t  reg_write_addr;
        alu_op_t    aluop;
        alu_sel_t   alusel;
        logic       use_imm;
        word_t      imm;
        excp_code_t excp;
    } decode_result_t;

    // Registered entry for the dispatch stage
    typedef struct packed {
        logic           valid;
        addr_t          pc;
        decode_result_t result;
    } dispatch_t;

    // Issue control
    typedef enum logic {
        ISSUE_RUN,
        ISSUE_HALT
    } issue_state_e;

endpackage

// ==== design/decoder_3r.sv ====
`timescale 1ns/1ps
`include "decode_params.svh"

// 3R format {opcode[17], rk[5], rj[5], rd[5]}
// Purely combinational
module decoder_3r (
    input  decode_pkg::instr_buffer_info_t instr_info_i,
    output decode_pkg::decode_result_t     result_o
);

    decode_pkg::word_t             instr;
    logic [`OPC_3R_WIDTH-1:0]      opcode;
    decode_pkg::reg_addr_t         rd;
    decode_pkg::reg_addr_t         rj;
    decode_pkg::reg_addr_t         rk;

    assign instr  = instr_info_i.instr;
    assign opcode = instr[31:15];
    assign rd     = instr[4:0];
    assign rj     = instr[9:5];
    assign rk     = instr[14:10];

    always_comb begin
        // Register-register default
        result_o.decode_valid    = instr_info_i.valid;
        result_o.reg_read_valid  = 2'b11;
        result_o.reg_read_addr   = {rj, rk};
        result_o.reg_write_valid = 1'b1;
        result_o.reg_write_addr  = rd;
        result_o.aluop           = `EXE_NOP_OP;
        result_o.alusel          = `EXE_RES_NOP;
        result_o.use_imm         = 1'b0;
        result_o.imm             = '0;
        result_o.excp            = `EXCP_NONE;
        case (opcode)
            `EXE_ADD_W: begin
                result_o.aluop  = `EXE_ADD_OP;
                result_o.alusel = `EXE_RES_ARITH;
            end
            `EXE_SUB_W: begin
                result_o.aluop  = `EXE_SUB_OP;
                result_o.alusel = `EXE_RES_ARITH;
            end
            `EXE_SLT: begin
                result_o.aluop  = `EXE_SLT_OP;
                result_o.alusel = `EXE_RES_ARITH;
            end
            `EXE_SLTU: begin
                result_o.aluop  = `EXE_SLTU_OP;
                result_o.alusel = `EXE_RES_ARITH;
            end
            `EXE_NOR: begin
                result_o.aluop  = `EXE_NOR_OP;
                result_o.alusel = `EXE_RES_LOGIC;
            end
            `EXE_AND: begin
                result_o.aluop  = `EXE_AND_OP;
                result_o.alusel = `EXE_RES_LOGIC;
            end
            `EXE_OR: begin
                result_o.aluop  = `EXE_OR_OP;
                result_o.alusel = `EXE_RES_LOGIC;
            end
            `EXE_XOR: begin
                result_o.aluop  = `EXE_XOR_OP;
                result_o.alusel = `EXE_RES_LOGIC;
            end
            `EXE_SLL_W: begin
                result_o.aluop  = `EXE_SLL_OP;
                result_o.alusel = `EXE_RES_SHIFT;
            end
            `EXE_SRL_W: begin
                result_o.aluop  = `EXE_SRL_OP;
                result_o.alusel = `EXE_RES_SHIFT;
            end
            `EXE_SRA_W: begin
                result_o.aluop  = `EXE_SRA_OP;
                result_o.alusel = `EXE_RES_SHIFT;
            end
            `EXE_MUL_W: begin
                result_o.aluop  = `EXE_MUL_OP;
                result_o.alusel = `EXE_RES_ARITH;
            end
            `EXE_MULH_W: begin
                result_o.aluop  = `EXE_MULH_OP;
                result_o.alusel = `EXE_RES_ARITH;
            end
            `EXE_MULH_WU: begin
                result_o.aluop  = `EXE_MULHU_OP;
                result_o.alusel = `EXE_RES_ARITH;
            end
            `EXE_DIV_W: begin
                result_o.aluop  = `EXE_DIV_OP;
                result_o.alusel = `EXE_RES_ARITH;
            end
            `EXE_DIV_WU: begin
                result_o.aluop  = `EXE_DIVU_OP;
                result_o.alusel = `EXE_RES_ARITH;
            end
            `EXE_MOD_W: begin
                result_o.aluop  = `EXE_MOD_OP;
                result_o.alusel = `EXE_RES_ARITH;
            end
            `EXE_MOD_WU: begin
                result_o.aluop  = `EXE_MODU_OP;
                result_o.alusel = `EXE_RES_ARITH;
            end
            `EXE_BREAK, `EXE_SYSCALL: begin
                // No GPR traffic, only the trap
                result_o.reg_read_valid  = 2'b00;
                result_o.reg_read_addr   = '0;
                result_o.reg_write_valid = 1'b0;
                result_o.reg_write_addr  = '0;
                result_o.excp = (opcode == `EXE_BREAK) ? `EXCP_BRK : `EXCP_SYS;
            end
            `EXE_IDLE, `EXE_DBAR, `EXE_IBAR, `EXE_INVTLB: begin
                // Not implemented yet, pass through as no-ops
                result_o.reg_read_valid  = 2'b00;
                result_o.reg_read_addr   = '0;
                result_o.reg_write_valid = 1'b0;
                result_o.reg_write_addr  = '0;
                if (opcode == `EXE_INVTLB) begin
                    result_o.aluop = `EXE_INVTLB_OP;
                end
            end
            default: begin
                result_o.decode_valid    = 1'b0;
                result_o.reg_read_valid  = 2'b00;
                result_o.reg_read_addr   = '0;
                result_o.reg_write_valid = 1'b0;
                result_o.reg_write_addr  = '0;
            end
        endcase
    end

endmodule

// ==== design/decoder_2ri12.sv ====
`timescale 1ns/1ps
`include "decode_params.svh"

// 2RI12 format {opcode[10], si12[12], rj[5], rd[5]}
// Purely combinational
module decoder_2ri12 (
    input  decode_pkg::instr_buffer_info_t instr_info_i,
    output decode_pkg::decode_result_t     result_o
);

    decode_pkg::word_t            instr;
    logic [`OPC_2RI12_WIDTH-1:0]  opcode;
    logic [`IMM12_WIDTH-1:0]      imm12;
    decode_pkg::reg_addr_t        rd;
    decode_pkg::reg_addr_t        rj;
    decode_pkg::word_t            imm_sext;
    decode_pkg::word_t            imm_zext;

    assign instr  = instr_info_i.instr;
    assign opcode = instr[31:22];
    assign imm12  = instr[21:10];
    assign rd     = instr[4:0];
    assign rj     = instr[9:5];

    // Arithmetic ops sign-extend, logic ops zero-extend
    assign imm_sext = {{(`DATA_WIDTH-`IMM12_WIDTH){imm12[`IMM12_WIDTH-1]}}, imm12};
    assign imm_zext = {{(`DATA_WIDTH-`IMM12_WIDTH){1'b0}}, imm12};

    always_comb begin
        // Only rj is read, rk slot stays empty
        result_o.decode_valid    = instr_info_i.valid;
        result_o.reg_read_valid  = 2'b10;
        result_o.reg_read_addr   = {rj, 5'd0};
        result_o.reg_write_valid = 1'b1;
        result_o.reg_write_addr  = rd;
        result_o.aluop           = `EXE_NOP_OP;
        result_o.alusel          = `EXE_RES_NOP;
        result_o.use_imm         = 1'b1;
        result_o.imm             = imm_sext;
        result_o.excp            = `EXCP_NONE;
        case (opcode)
            `EXE_ADDI_W: begin
                result_o.aluop  = `EXE_ADD_OP;
                result_o.alusel = `EXE_RES_ARITH;
            end
            `EXE_SLTI: begin
                result_o.aluop  = `EXE_SLT_OP;
                result_o.alusel = `EXE_RES_ARITH;
            end
            `EXE_SLTUI: begin
                // Compared unsigned, but the immediate is still sign-extended
                result_o.aluop  = `EXE_SLTU_OP;
                result_o.alusel = `EXE_RES_ARITH;
            end
            `EXE_ANDI: begin
                result_o.aluop  = `EXE_AND_OP;
                result_o.alusel = `EXE_RES_LOGIC;
                result_o.imm    = imm_zext;
            end
            `EXE_ORI: begin
                result_o.aluop  = `EXE_OR_OP;
                result_o.alusel = `EXE_RES_LOGIC;
                result_o.imm    = imm_zext;
            end
            `EXE_XORI: begin
                result_o.aluop  = `EXE_XOR_OP;
                result_o.alusel = `EXE_RES_LOGIC;
                result_o.imm    = imm_zext;
            end
            default: begin
                result_o.decode_valid    = 1'b0;
                result_o.reg_read_valid  = 2'b00;
                result_o.reg_read_addr   = '0;
                result_o.reg_write_valid = 1'b0;
                result_o.reg_write_addr  = '0;
                result_o.use_imm         = 1'b0;
                result_o.imm             = '0;
            end
        endcase
    end

endmodule

// ==== design/decode_ctrl.sv ====
`timescale 1ns/1ps
`include "decode_params.svh"

// Two-state issue control
// Halts after a trapping or illegal instruction, resumes on flush
module decode_ctrl (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  logic                   fire_i,
    input  decode_pkg::excp_code_t excp_i,
    input  logic                   flush_i,
    output logic                   issue_en_o,
    output logic                   halted_o
);

    decode_pkg::issue_state_e state_q;
    decode_pkg::issue_state_e state_d;

    always_comb begin
        state_d = state_q;
        case (state_q)
            decode_pkg::ISSUE_RUN: begin
                // Flush wins over an accepted instruction
                if (flush_i) begin
                    state_d = decode_pkg::ISSUE_RUN;
                end else if (fire_i && (excp_i != `EXCP_NONE)) begin
                    state_d = decode_pkg::ISSUE_HALT;
                end
            end
            decode_pkg::ISSUE_HALT: begin
                if (flush_i) begin
                    state_d = decode_pkg::ISSUE_RUN;
                end
            end
            default: begin
                state_d = decode_pkg::ISSUE_RUN;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= decode_pkg::ISSUE_RUN;
        end else begin
            state_q <= state_d;
        end
    end

    // Moore outputs
    assign issue_en_o = (state_q == decode_pkg::ISSUE_RUN);
    assign halted_o   = (state_q == decode_pkg::ISSUE_HALT);

endmodule

// ==== design/id_stage.sv ====
`timescale 1ns/1ps
`include "decode_params.svh"

// Instruction decode stage
// One cycle from accepted buffer entry to dispatch register
module id_stage (
    input  logic                           clk,
    input  logic                           rst_n_i,
    input  decode_pkg::instr_buffer_info_t instr_i,
    input  logic                           stall_i,
    input  logic                           flush_i,
    output decode_pkg::dispatch_t          dispatch_o,
    output logic                           halted_o
);

    decode_pkg::decode_result_t res_3r;
    decode_pkg::decode_result_t res_2ri12;
    decode_pkg::decode_result_t res_sel;
    logic                       issue_en;
    logic                       fire;

    // Dispatch register, valid bit kept apart from the payload
    logic                       disp_valid_q;
    decode_pkg::addr_t          disp_pc_q;
    decode_pkg::decode_result_t disp_result_q;

    decoder_3r u_decoder_3r (
        .instr_info_i (instr_i),
        .result_o     (res_3r)
    );

    decoder_2ri12 u_decoder_2ri12 (
        .instr_info_i (instr_i),
        .result_o     (res_2ri12)
    );

    // The formats never overlap, so at most one is valid
    always_comb begin
        res_sel = '0;
        if (res_3r.decode_valid) begin
            res_sel = res_3r;
        end else if (res_2ri12.decode_valid) begin
            res_sel = res_2ri12;
        end else if (instr_i.valid) begin
            res_sel.excp = `EXCP_INE;
        end
    end

    // Entry accepted this cycle
    assign fire = instr_i.valid && !stall_i && issue_en && !flush_i;

    decode_ctrl u_decode_ctrl (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .fire_i     (fire),
        .excp_i     (res_sel.excp),
        .flush_i    (flush_i),
        .issue_en_o (issue_en),
        .halted_o   (halted_o)
    );

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            disp_valid_q <= 1'b0;
        end else if (flush_i) begin
            disp_valid_q <= 1'b0;
        end else if (!stall_i) begin
            disp_valid_q <= fire;
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            disp_pc_q     <= instr_i.pc;
            disp_result_q <= res_sel;
        end
    end

    assign dispatch_o.valid  = disp_valid_q;
    assign dispatch_o.pc     = disp_pc_q;
    assign dispatch_o.result = disp_result_q;

endmodule

// ==== testbench/tb_id_stage.sv ====
`timescale 1ns/1ps
`include "decode_params.svh"

module tb_id_stage;

    localparam int RESET_TIMEOUT = 20;

    // One table row holds the stimulus and the dispatch expected after its edge
    typedef struct packed {
        decode_pkg::addr_t      pc;
        decode_pkg::word_t      instr;
        logic                   valid;
        logic                   stall;
        logic                   flush;
        logic                   exp_valid;
        decode_pkg::addr_t      exp_pc;
        decode_pkg::alu_op_t    exp_aluop;
        decode_pkg::alu_sel_t   exp_alusel;
        logic [1:0]             exp_rd_valid;
        logic [9:0]             exp_rd_addr;
        logic                   exp_wr_valid;
        decode_pkg::reg_addr_t  exp_wr_addr;
        logic                   exp_use_imm;
        decode_pkg::word_t      exp_imm;
        decode_pkg::excp_code_t exp_excp;
        logic                   exp_halted;
    } row_t;

    logic                           clk;
    logic                           rst_n;
    decode_pkg::instr_buffer_info_t buf_entry;
    logic                           stall;
    logic                           flush;
    decode_pkg::dispatch_t          dispatch;
    logic                           halted;

    row_t              rows[$];
    decode_pkg::addr_t next_pc;
    int unsigned       seed;
    int                i;
    int                wait_cycles;

    id_stage dut_i (
        .clk        (clk),
        .rst_n_i    (rst_n),
        .instr_i    (buf_entry),
        .stall_i    (stall),
        .flush_i    (flush),
        .dispatch_o (dispatch),
        .halted_o   (halted)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
    end

    function automatic decode_pkg::reg_addr_t rand_reg();
        return decode_pkg::reg_addr_t'($urandom % `GPR_NUM);
    endfunction

    task automatic new_row(output row_t r);
        r        = '0;
        r.pc     = next_pc;
        r.exp_pc = next_pc;
        r.valid  = 1'b1;
        next_pc  = next_pc + 4;
    endtask

    task automatic add_3r(input logic [`OPC_3R_WIDTH-1:0] opcode,
                          input decode_pkg::alu_op_t aluop,
                          input decode_pkg::alu_sel_t alusel);
        row_t                  r;
        decode_pkg::reg_addr_t rd;
        decode_pkg::reg_addr_t rj;
        decode_pkg::reg_addr_t rk;
        rd = rand_reg();
        rj = rand_reg();
        rk = rand_reg();
        new_row(r);
        r.instr        = {opcode, rk, rj, rd};
        r.exp_valid    = 1'b1;
        r.exp_aluop    = aluop;
        r.exp_alusel   = alusel;
        r.exp_rd_valid = 2'b11;
        r.exp_rd_addr  = {rj, rk};
        r.exp_wr_valid = 1'b1;
        r.exp_wr_addr  = rd;
        rows.push_back(r);
    endtask

    task automatic add_2ri12(input logic [`OPC_2RI12_WIDTH-1:0] opcode,
                             input decode_pkg::alu_op_t aluop,
                             input decode_pkg::alu_sel_t alusel,
                             input logic sign_ext,
                             input logic neg);
        row_t                    r;
        decode_pkg::reg_addr_t   rd;
        decode_pkg::reg_addr_t   rj;
        logic [`IMM12_WIDTH-1:0] imm12;
        rd = rand_reg();
        rj = rand_reg();
        imm12 = `IMM12_WIDTH'($urandom);
        // Force the top bit so both extension cases are covered
        imm12[`IMM12_WIDTH-1] = neg;
        new_row(r);
        r.instr        = {opcode, imm12, rj, rd};
        r.exp_valid    = 1'b1;
        r.exp_aluop    = aluop;
        r.exp_alusel   = alusel;
        r.exp_rd_valid = 2'b10;
        r.exp_rd_addr  = {rj, 5'd0};
        r.exp_wr_valid = 1'b1;
        r.exp_wr_addr  = rd;
        r.exp_use_imm  = 1'b1;
        if (sign_ext) begin
            r.exp_imm = decode_pkg::word_t'($signed(imm12));
        end else begin
            r.exp_imm = decode_pkg::word_t'(imm12);
        end
        rows.push_back(r);
    endtask

    // Trap and illegal rows carry only the exception code and halt issue
    task automatic add_excp(input decode_pkg::word_t instr, input decode_pkg::excp_code_t excp);
        row_t r;
        new_row(r);
        r.instr      = instr;
        r.exp_valid  = 1'b1;
        r.exp_excp   = excp;
        r.exp_halted = 1'b1;
        rows.push_back(r);
    endtask

    // Valid entry offered while halted is not dispatched
    task automatic add_blocked();
        row_t r;
        new_row(r);
        r.instr      = {`EXE_ADD_W, 15'($urandom)};
        r.exp_halted = 1'b1;
        rows.push_back(r);
    endtask

    task automatic add_flush(input logic in_stall);
        row_t r;
        new_row(r);
        r.instr = {`EXE_OR, 15'($urandom)};
        r.stall = in_stall;
        r.flush = 1'b1;
        rows.push_back(r);
    endtask

    // Offer a 3R entry under stall for some cycles, then release it
    task automatic add_stalled_3r(input logic [`OPC_3R_WIDTH-1:0] opcode,
                                  input decode_pkg::alu_op_t aluop,
                                  input decode_pkg::alu_sel_t alusel,
                                  input int cycles);
        row_t held;
        row_t nxt;
        row_t st;
        held = rows[$];
        add_3r(opcode, aluop, alusel);
        nxt = rows.pop_back();
        repeat (cycles) begin
            st       = held;
            st.pc    = nxt.pc;
            st.instr = nxt.instr;
            st.valid = 1'b1;
            st.stall = 1'b1;
            st.flush = 1'b0;
            rows.push_back(st);
        end
        rows.push_back(nxt);
    endtask

    task automatic build_table();
        int n;
        add_3r(`EXE_ADD_W, `EXE_ADD_OP, `EXE_RES_ARITH);
        add_3r(`EXE_SUB_W, `EXE_SUB_OP, `EXE_RES_ARITH);
        add_3r(`EXE_SLT, `EXE_SLT_OP, `EXE_RES_ARITH);
        add_3r(`EXE_SLTU, `EXE_SLTU_OP, `EXE_RES_ARITH);
        add_3r(`EXE_NOR, `EXE_NOR_OP, `EXE_RES_LOGIC);
        add_3r(`EXE_AND, `EXE_AND_OP, `EXE_RES_LOGIC);
        add_3r(`EXE_OR, `EXE_OR_OP, `EXE_RES_LOGIC);
        add_3r(`EXE_XOR, `EXE_XOR_OP, `EXE_RES_LOGIC);
        add_3r(`EXE_SLL_W, `EXE_SLL_OP, `EXE_RES_SHIFT);
        add_3r(`EXE_SRL_W, `EXE_SRL_OP, `EXE_RES_SHIFT);
        add_3r(`EXE_SRA_W, `EXE_SRA_OP, `EXE_RES_SHIFT);
        add_3r(`EXE_MUL_W, `EXE_MUL_OP, `EXE_RES_ARITH);
        add_3r(`EXE_MULH_W, `EXE_MULH_OP, `EXE_RES_ARITH);
        add_3r(`EXE_MULH_WU, `EXE_MULHU_OP, `EXE_RES_ARITH);
        add_3r(`EXE_DIV_W, `EXE_DIV_OP, `EXE_RES_ARITH);
        add_3r(`EXE_DIV_WU, `EXE_DIVU_OP, `EXE_RES_ARITH);
        add_3r(`EXE_MOD_W, `EXE_MOD_OP, `EXE_RES_ARITH);
        add_3r(`EXE_MOD_WU, `EXE_MODU_OP, `EXE_RES_ARITH);
        for (n = 0; n < 2; n++) begin
            add_2ri12(`EXE_ADDI_W, `EXE_ADD_OP, `EXE_RES_ARITH, 1'b1, n[0]);
            add_2ri12(`EXE_SLTI, `EXE_SLT_OP, `EXE_RES_ARITH, 1'b1, n[0]);
            add_2ri12(`EXE_SLTUI, `EXE_SLTU_OP, `EXE_RES_ARITH, 1'b1, n[0]);
            add_2ri12(`EXE_ANDI, `EXE_AND_OP, `EXE_RES_LOGIC, 1'b0, n[0]);
            add_2ri12(`EXE_ORI, `EXE_OR_OP, `EXE_RES_LOGIC, 1'b0, n[0]);
            add_2ri12(`EXE_XORI, `EXE_XOR_OP, `EXE_RES_LOGIC, 1'b0, n[0]);
        end
        add_stalled_3r(`EXE_ADD_W, `EXE_ADD_OP, `EXE_RES_ARITH, 3);
        add_excp({`EXE_BREAK, 15'($urandom)}, `EXCP_BRK);
        add_blocked();
        add_blocked();
        add_flush(1'b0);
        add_3r(`EXE_OR, `EXE_OR_OP, `EXE_RES_LOGIC);
        add_excp({`EXE_SYSCALL, 15'($urandom)}, `EXCP_SYS);
        add_blocked();
        add_flush(1'b0);
        add_2ri12(`EXE_ORI, `EXE_OR_OP, `EXE_RES_LOGIC, 1'b0, 1'b1);
        // All-ones top bits match neither format
        add_excp({10'h3ff, 22'($urandom)}, `EXCP_INE);
        add_blocked();
        add_flush(1'b0);
        add_3r(`EXE_SUB_W, `EXE_SUB_OP, `EXE_RES_ARITH);
        add_3r(`EXE_XOR, `EXE_XOR_OP, `EXE_RES_LOGIC);
        add_flush(1'b1);
        add_3r(`EXE_AND, `EXE_AND_OP, `EXE_RES_LOGIC);
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Mismatch at time %0t: %s is 0x%0h, expected 0x%0h",
                     $time, name, actual, expected);
            $display("CHECKS FAILED");
            $fatal(1, "Stopped at the first wrong value");
        end
    endtask

    task automatic apply_row(input row_t r);
        buf_entry.valid <= r.valid;
        buf_entry.pc    <= r.pc;
        buf_entry.instr <= r.instr;
        stall           <= r.stall;
        flush           <= r.flush;
    endtask

    task automatic check_row(input row_t r);
        check_value("dispatch_o.valid", dispatch.valid, r.exp_valid);
        check_value("halted_o", halted, r.exp_halted);
        // Payload only matters while valid
        if (r.exp_valid) begin
            check_value("dispatch_o.pc", dispatch.pc, r.exp_pc);
            check_value("result.decode_valid", dispatch.result.decode_valid,
                        r.exp_excp != `EXCP_INE);
            check_value("result.aluop", dispatch.result.aluop, r.exp_aluop);
            check_value("result.alusel", dispatch.result.alusel, r.exp_alusel);
            check_value("result.reg_read_valid", dispatch.result.reg_read_valid, r.exp_rd_valid);
            check_value("result.reg_read_addr", dispatch.result.reg_read_addr, r.exp_rd_addr);
            check_value("result.reg_write_valid", dispatch.result.reg_write_valid,
                        r.exp_wr_valid);
            check_value("result.reg_write_addr", dispatch.result.reg_write_addr, r.exp_wr_addr);
            check_value("result.use_imm", dispatch.result.use_imm, r.exp_use_imm);
            check_value("result.imm", dispatch.result.imm, r.exp_imm);
            check_value("result.excp", dispatch.result.excp, r.exp_excp);
        end
    endtask

    initial begin
        seed = 35299;
        void'($urandom(seed));
        buf_entry = '0;
        stall     = 1'b0;
        flush     = 1'b0;
        next_pc   = 32'h1c00_0000;
        build_table();

        wait_cycles = 0;
        while (rst_n !== 1'b1) begin
            @(posedge clk);
            wait_cycles = wait_cycles + 1;
            if (wait_cycles > RESET_TIMEOUT) begin
                $display("Reset was not released within %0d cycles", RESET_TIMEOUT);
                $display("CHECKS FAILED");
                $fatal(1, "Reset wait timed out");
            end
        end
        @(negedge clk);
        check_value("dispatch_o.valid", dispatch.valid, 1'b0);
        check_value("halted_o", halted, 1'b0);

        // Row i goes in at the edge that dispatches row i-1
        for (i = 0; i <= rows.size(); i++) begin
            @(posedge clk);
            if (i < rows.size()) begin
                apply_row(rows[i]);
            end else begin
                buf_entry.valid <= 1'b0;
                stall           <= 1'b0;
                flush           <= 1'b0;
            end
            @(negedge clk);
            if (i > 0) begin
                check_row(rows[i-1]);
            end
        end

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+include
design/decode_pkg.sv
design/decoder_3r.sv
design/decoder_2ri12.sv
design/decode_ctrl.sv
design/id_stage.sv
testbench/tb_id_stage.sv

// ==== Bender.yml ====
package:
  name: id_stage

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - design/decode_pkg.sv
      - design/decoder_3r.sv
      - design/decoder_2ri12.sv
      - design/decode_ctrl.sv
      - design/id_stage.sv
  - target: test
    include_dirs:
      - include
    files:
      - testbench/tb_id_stage.sv
